/* design/secDecoder_consts.svh */
// fixed code geometry; the syndrome equations are written for 32 data and 8 check bits only
`ifndef SEC_DECODER_CONSTS_SVH
`define SEC_DECODER_CONSTS_SVH

`default_nettype none

`define SEC_DATA_W   32  // data bits per word
`define SEC_CHECK_W  8   // check bits per word
`define SEC_NIBBLE_W 4   // bits per nibble
`define SEC_NIBBLES  8   // nibbles per data word

`default_nettype wire

`endif

/* design/secCodePkg.sv */
// codeword types; all vectors are numbered from 0 at the most significant end
`include "secDecoder_consts.svh"

`default_nettype none

package secCodePkg;

  // ==================================================
  // codeword fields
  // ==================================================

  // data word, bit 0 is the msb
  typedef logic [0:`SEC_DATA_W-1] dataWordT;

  // check byte as it travels with the word
  typedef logic [0:`SEC_CHECK_W-1] checkByteT;

  // syndrome, low half is bits 0..3 and high half bits 4..7
  typedef logic [0:`SEC_CHECK_W-1] syndromeT;

  // ==================================================
  // helper types
  // ==================================================

  // one half of the syndrome or one group of column parities
  typedef logic [0:`SEC_NIBBLE_W-1] synHalfT;

  // nibble number inside the data word
  typedef logic [$clog2(`SEC_NIBBLES)-1:0] nibbleIdxT;

  // bit number inside a nibble
  typedef logic [$clog2(`SEC_NIBBLE_W)-1:0] bitPosT;

endpackage

`default_nettype wire

/* design/secPipePkg.sv */
// payloads between the pipeline stages; the second stage carries a plain secCodePkg::dataWordT
`include "secDecoder_consts.svh"

`default_nettype none

package secPipePkg;

  import secCodePkg::*;

  // ==================================================
  // stage payloads
  // ==================================================

  // item as it enters the decoder
  typedef struct packed {
    dataWordT  data;     // possibly corrupted data
    checkByteT check;    // received check bits
    logic      checkEn;  // low ignores the check byte
  } codeInT;

  // item after the syndrome stage
  typedef struct packed {
    dataWordT data;  // data, still uncorrected
    syndromeT synd;  // syndrome of that data
  } syndItemT;

endpackage

`default_nettype wire

/* design/syndromeCalc.sv */
// purely combinational; the checkEn gate only masks the check byte, it never blocks the data
`timescale 1ns/1ps
`include "secDecoder_consts.svh"

`default_nettype none

module syndromeCalc (
  input  secPipePkg::codeInT   item,
  output secPipePkg::syndItemT syndItem
);

  import secCodePkg::*;

  logic [0:`SEC_NIBBLES-1] nibPar;  // parity of each nibble
  synHalfT   lowCol;      // column parity over nibbles 0..3
  synHalfT   highCol;     // column parity over nibbles 4..7
  synHalfT   lowCross;    // nibble pairs 0..3, into the high half
  synHalfT   highCross;   // nibble pairs 4..7, into the low half
  checkByteT gatedCheck;
  syndromeT  synd;

  // ==================================================
  // parity terms
  // ==================================================

  always_comb begin
    for (int k = 0; k < `SEC_NIBBLES; k++) begin
      nibPar[k] = ^item.data[k*`SEC_NIBBLE_W +: `SEC_NIBBLE_W];
    end
  end

  always_comb begin
    for (int j = 0; j < `SEC_NIBBLE_W; j++) begin
      lowCol[j]  = item.data[j] ^ item.data[j+4] ^ item.data[j+8] ^ item.data[j+12];
      highCol[j] = item.data[j+16] ^ item.data[j+20] ^ item.data[j+24] ^ item.data[j+28];
    end
  end

  // each nibble hits two of the four cross terms
  assign highCross = {nibPar[4] ^ nibPar[5], nibPar[6] ^ nibPar[7],
                      nibPar[4] ^ nibPar[6], nibPar[5] ^ nibPar[7]};
  assign lowCross  = {nibPar[0] ^ nibPar[1], nibPar[2] ^ nibPar[3],
                      nibPar[0] ^ nibPar[2], nibPar[1] ^ nibPar[3]};

  // ==================================================
  // syndrome
  // ==================================================

  assign gatedCheck = item.check & {`SEC_CHECK_W{item.checkEn}};

  assign synd[0:3] = lowCol ^ highCross ^ gatedCheck[0:3];
  assign synd[4:7] = highCol ^ lowCross ^ gatedCheck[4:7];

  assign syndItem = '{data: item.data, synd: synd};  // data rides along unchanged

endmodule

`default_nettype wire

/* design/errorCorrect.sv */
// corrects single data-bit errors only; every other syndrome, multi-bit ones included, passes data
`timescale 1ns/1ps
`include "secDecoder_consts.svh"

`default_nettype none

module errorCorrect (
  input  secPipePkg::syndItemT syndItem,
  output secCodePkg::dataWordT corrected
);

  import secCodePkg::*;

  synHalfT   lowHalf;
  synHalfT   highHalf;
  logic      lowOneHot;
  logic      highOneHot;
  logic      lowIsPat;
  logic      highIsPat;
  bitPosT    lowCode;
  bitPosT    highCode;
  bitPosT    lowPos;
  bitPosT    highPos;
  logic      errHit;
  nibbleIdxT errNibble;
  bitPosT    errBit;
  dataWordT  errMask;

  // 1010, 1001, 0110, 0101 name nibbles 0..3 of the opposite half
  function automatic logic isPattern(input synHalfT half);
    return (half == 4'b1010) || (half == 4'b1001) || (half == 4'b0110) || (half == 4'b0101);
  endfunction

  function automatic bitPosT patternCode(input synHalfT half);
    bitPosT code;
    case (half)
      4'b1001: code = 2'd1;
      4'b0110: code = 2'd2;
      4'b0101: code = 2'd3;
      default: code = 2'd0;  // 1010, others are masked by isPattern
    endcase
    return code;
  endfunction

  function automatic bitPosT oneHotPos(input synHalfT half);
    bitPosT pos;
    pos = '0;
    for (int j = 0; j < `SEC_NIBBLE_W; j++) begin
      if (half[j]) pos = bitPosT'(j);
    end
    return pos;
  endfunction

  // ==================================================
  // locate the flipped bit
  // ==================================================

  assign lowHalf    = syndItem.synd[0:3];
  assign highHalf   = syndItem.synd[4:7];
  assign lowOneHot  = $onehot(lowHalf);
  assign highOneHot = $onehot(highHalf);
  assign lowIsPat   = isPattern(lowHalf);
  assign highIsPat  = isPattern(highHalf);
  assign lowCode    = patternCode(lowHalf);
  assign highCode   = patternCode(highHalf);
  assign lowPos     = oneHotPos(lowHalf);
  assign highPos    = oneHotPos(highHalf);

  // a half cannot be one-hot and a pattern at once, so at most one branch hits
  always_comb begin
    errHit    = 1'b0;
    errNibble = '0;
    errBit    = '0;
    if (lowOneHot && highIsPat) begin    // nibbles 0..3
      errHit    = 1'b1;
      errNibble = {1'b0, highCode};
      errBit    = lowPos;
    end else if (highOneHot && lowIsPat) begin  // nibbles 4..7
      errHit    = 1'b1;
      errNibble = {1'b1, lowCode};
      errBit    = highPos;
    end
  end

  always_comb begin
    errMask = '0;
    if (errHit) errMask[{errNibble, errBit}] = 1'b1;  // index counts from the msb
  end

  assign corrected = syndItem.data ^ errMask;

endmodule

`default_nettype wire

/* design/pipeStage.sv */
// one-entry slice; inReady depends combinationally on outReady, so ready paths chain through stages
`timescale 1ns/1ps

`default_nettype none

module pipeStage #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    inValid,
  output logic    inReady,
  input  payloadT inPayload,
  output logic    outValid,
  input  logic    outReady,
  output payloadT outPayload
);

  logic    full;     // entry holds an item
  payloadT entry;

  // accept when empty or when the held item leaves this cycle
  assign inReady = !full || outReady;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      full <= 1'b0;
    end else if (inReady) begin
      full <= inValid;  // refill or go empty
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) entry <= inPayload;
  end

  assign outValid   = full;
  assign outPayload = entry;

endmodule

`default_nettype wire

/* design/secDecoderTop.sv */
// two-cycle decoder; holds at most two items, and a stalled output backs up to inReady
`timescale 1ns/1ps

`default_nettype none

module secDecoderTop (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 inValid,
  output logic                 inReady,
  input  secPipePkg::codeInT   inItem,
  output logic                 outValid,
  input  logic                 outReady,
  output secCodePkg::dataWordT outData
);

  import secCodePkg::*;
  import secPipePkg::*;

  syndItemT syndIn;    // syndrome of the incoming item
  syndItemT s1Item;
  logic     s1Valid;
  logic     s1Ready;
  dataWordT corrWord;  // corrected word into the last stage

  // ==================================================
  // stage 1, syndrome
  // ==================================================

  syndromeCalc syndCalc (
    .item     (inItem),
    .syndItem (syndIn)
  );

  pipeStage #(.payloadT(syndItemT)) s1Stage (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (inValid),
    .inReady    (inReady),
    .inPayload  (syndIn),
    .outValid   (s1Valid),
    .outReady   (s1Ready),
    .outPayload (s1Item)
  );

  // ==================================================
  // stage 2, correction
  // ==================================================

  errorCorrect errCorr (
    .syndItem  (s1Item),
    .corrected (corrWord)
  );

  pipeStage #(.payloadT(dataWordT)) s2Stage (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (s1Valid),
    .inReady    (s1Ready),
    .inPayload  (corrWord),
    .outValid   (outValid),
    .outReady   (outReady),
    .outPayload (outData)
  );

endmodule

`default_nettype wire

/* verification/secDecoderChk.sv */
// port protocol checks for the decoder top; single clock, asynchronous active-low reset
`timescale 1ns/1ps

`default_nettype none

module secDecoderChk (
  input logic                 clk,
  input logic                 rstN,
  input logic                 inReady,
  input logic                 outValid,
  input logic                 outReady,
  input secCodePkg::dataWordT outData
);

  int assertFails = 0;  // summed into the testbench error total

  // ==================================================
  // output stream
  // ==================================================

  holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
      outValid && !outReady |=> outValid && $stable(outData))
    else begin
      assertFails++;
      $error("output item dropped or changed while outReady was low");
    end

  idleInReset: assert property (@(posedge clk) !rstN |-> !outValid)
    else begin
      assertFails++;
      $error("outValid high during reset");
    end

  // both stages are empty right after reset
  readyAfterReset: assert property (@(posedge clk) $rose(rstN) |-> inReady)
    else begin
      assertFails++;
      $error("inReady low on the first cycle after reset");
    end

endmodule

`default_nettype wire

/* verification/secDecoderTb.sv */
// directed tests only; expected words come from a model of the syndrome rules with bit 0 as the msb
`timescale 1ns/1ps
`include "secDecoder_consts.svh"

`default_nettype none

module secDecoderTb;

  import secCodePkg::*;
  import secPipePkg::*;

  localparam int maxCycles = 2000;  // about 80 items of a few cycles each plus stalls

  logic     clk;
  logic     rstN;
  logic     inValid;
  logic     inReady;
  codeInT   inItem;
  logic     outValid;
  logic     outReady;
  dataWordT outData;

  int       errors = 0;
  int       cycles = 0;
  int       acceptCycle;   // edge of the last input transfer
  int       outCycle;      // edge of the last output transfer
  string    testName;
  dataWordT expQ[$];       // expected words in order
  string    nameQ[$];

  secDecoderTop DUT (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inReady  (inReady),
    .inItem   (inItem),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
  );

  bind secDecoderTop secDecoderChk protoChk (
    .clk      (clk),
    .rstN     (rstN),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  always @(posedge clk) begin
    if (cycles >= maxCycles) begin
      $display("timeout: the tests did not finish within %0d cycles", maxCycles);
      $display("Checks failed");
      $finish;
    end
  end

  // ==================================================
  // reference model
  // ==================================================

  function automatic syndromeT modelSyndrome(input dataWordT d, input checkByteT c,
                                             input logic en);
    logic [0:`SEC_NIBBLES-1] par;
    logic [0:3] intoLow;
    logic [0:3] intoHigh;
    syndromeT   s;
    for (int k = 0; k < `SEC_NIBBLES; k++) par[k] = ^d[4*k +: 4];
    intoLow  = {par[4] ^ par[5], par[6] ^ par[7], par[4] ^ par[6], par[5] ^ par[7]};
    intoHigh = {par[0] ^ par[1], par[2] ^ par[3], par[0] ^ par[2], par[1] ^ par[3]};
    for (int j = 0; j < 4; j++) begin
      s[j]   = d[j] ^ d[j+4] ^ d[j+8] ^ d[j+12] ^ intoLow[j] ^ (c[j] & en);
      s[4+j] = d[j+16] ^ d[j+20] ^ d[j+24] ^ d[j+28] ^ intoHigh[j] ^ (c[4+j] & en);
    end
    return s;
  endfunction

  // check byte that zeroes the syndrome
  function automatic checkByteT checkFor(input dataWordT d);
    return modelSyndrome(d, '0, 1'b0);
  endfunction

  function automatic int patternNibble(input logic [0:3] h);
    case (h)
      4'b1010: return 0;
      4'b1001: return 1;
      4'b0110: return 2;
      4'b0101: return 3;
      default: return -1;
    endcase
  endfunction

  function automatic int onlyBit(input logic [0:3] h);
    int pos;
    int ones;
    pos  = -1;
    ones = 0;
    for (int j = 0; j < 4; j++) begin
      if (h[j]) begin
        pos = j;
        ones++;
      end
    end
    return (ones == 1) ? pos : -1;
  endfunction

  function automatic dataWordT modelCorrect(input dataWordT d, input checkByteT c,
                                            input logic en);
    syndromeT s;
    dataWordT fixed;
    s     = modelSyndrome(d, c, en);
    fixed = d;
    if (onlyBit(s[0:3]) >= 0 && patternNibble(s[4:7]) >= 0) begin
      fixed[4*patternNibble(s[4:7]) + onlyBit(s[0:3])] ^= 1'b1;
    end else if (onlyBit(s[4:7]) >= 0 && patternNibble(s[0:3]) >= 0) begin
      fixed[16 + 4*patternNibble(s[0:3]) + onlyBit(s[4:7])] ^= 1'b1;
    end
    return fixed;
  endfunction

  // ==================================================
  // stream driver and monitor
  // ==================================================

  task automatic sendItem(input dataWordT data, input checkByteT check, input logic en,
                          input dataWordT expWord);
    @(negedge clk);
    inItem  = '{data: data, check: check, checkEn: en};
    inValid = 1'b1;
    expQ.push_back(expWord);
    nameQ.push_back(testName);
    do begin
      @(posedge clk);
    end while (!inReady);
    acceptCycle = cycles;
  endtask

  task automatic drain();
    @(negedge clk);
    inValid = 1'b0;
    while (expQ.size() != 0) @(negedge clk);
  endtask

  always @(posedge clk) begin
    dataWordT expWord;
    string    tName;
    if (rstN && outValid && outReady) begin
      outCycle = cycles;
      if (expQ.size() == 0) begin
        errors++;
        $display("output word %h arrived with nothing outstanding", outData);
      end else begin
        expWord = expQ.pop_front();
        tName   = nameQ.pop_front();
        if (outData !== expWord) begin
          errors++;
          $display("CHECK FAILED %s: expected %h, actual %h", tName, expWord, outData);
        end
      end
    end
  end

  // ==================================================
  // directed tests
  // ==================================================

  task automatic cleanWords();
    dataWordT d;
    testName = "cleanWords";
    for (int i = 0; i < 20; i++) begin
      d = $urandom();
      sendItem(d, checkFor(d), 1'b1, d);
    end
    drain();
  endtask

  task automatic singleDataError();
    dataWordT base;
    dataWordT bad;
    testName = "singleDataError";
    base = $urandom();
    for (int i = 0; i < `SEC_DATA_W; i++) begin
      bad    = base;
      bad[i] = ~bad[i];
      sendItem(bad, checkFor(base), 1'b1, base);
    end
    drain();
  endtask

  task automatic checkBitError();
    dataWordT  d;
    checkByteT c;
    testName = "checkBitError";
    d = $urandom();
    for (int j = 0; j < `SEC_CHECK_W; j++) begin
      c    = checkFor(d);
      c[j] = ~c[j];
      sendItem(d, c, 1'b1, d);
    end
    drain();
  endtask

  task automatic enableGate();
    dataWordT  d;
    dataWordT  steer;
    checkByteT c;
    int        pos;
    testName = "enableGate";
    for (int i = 0; i < 10; i++) begin
      d          = $urandom();
      pos        = $urandom_range(`SEC_DATA_W-1);
      steer      = d;
      steer[pos] = ~steer[pos];
      c          = checkFor(steer);  // would point at one data bit if it were not gated
      sendItem(d, c, 1'b0, modelCorrect(d, '0, 1'b1));
    end
    drain();
  endtask

  task automatic latencyAndStall();
    dataWordT d;
    testName = "latencyAndStall";
    d = $urandom();
    sendItem(d, checkFor(d), 1'b1, d);
    drain();
    if (outCycle - acceptCycle != 2) begin
      errors++;
      $display("CHECK FAILED %s: expected latency %0d, actual %0d", testName, 2,
               outCycle - acceptCycle);
    end
    @(negedge clk);
    outReady = 1'b0;
    for (int i = 0; i < 2; i++) begin
      d = $urandom();
      sendItem(d, checkFor(d), 1'b1, d);
    end
    @(negedge clk);
    inValid = 1'b0;
    repeat (4) begin
      @(negedge clk);
      if (inReady !== 1'b0) begin
        errors++;
        $display("CHECK FAILED %s: expected inReady %b, actual %b", testName, 1'b0,
                 inReady);
      end
    end
    outReady = 1'b1;  // release so the third item follows the held two
    d = $urandom();
    sendItem(d, checkFor(d), 1'b1, d);
    drain();
  endtask

  initial begin
    void'($urandom(32'h7b85));
    rstN     = 1'b0;
    inValid  = 1'b0;
    inItem   = '0;
    outReady = 1'b1;
    testName = "reset";
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    cleanWords();
    singleDataError();
    checkBitError();
    enableGate();
    latencyAndStall();

    repeat (3) @(negedge clk);
    $display("%0d check errors, %0d assertion failures", errors, DUT.protoChk.assertFails);
    if (errors == 0 && DUT.protoChk.assertFails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/secCodePkg.sv
design/secPipePkg.sv
design/syndromeCalc.sv
design/errorCorrect.sv
design/pipeStage.sv
design/secDecoderTop.sv
verification/secDecoderChk.sv
verification/secDecoderTb.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= secDecoderTb
FILELIST    ?= src.f
BUILD_DIR   ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only --timing -Wall
SIM_ARGS    ?= +verilator+error+limit+100
PASS_TEXT   ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run fails unless the pass message shows up in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
